//--- decodeFrontEnd.sv
module decodeFrontEnd #(
    parameter int memDepthLog2 = 6,
    parameter int fifoDepth = 4
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                loadEn,
    input  logic [memDepthLog2-1:0]             loadAddr,
    input  logic [frontCfgPkg::instrWidth-1:0]  loadData,
    input  logic                                runEn,
    input  logic                                hold,
    output logic                                outValid,
    output logic [frontCfgPkg::xlen-1:0]        pc,
    output logic [frontCfgPkg::xlen-1:0]        imm,
    output logic [4:0]                          rs1,
    output logic [4:0]                          rs2,
    output logic [4:0]                          rd,
    output logic                                aluASrc,
    output logic [rvIsaPkg::aluBSrcWidth-1:0]   aluBSrc,
    output logic [rvIsaPkg::aluCtlWidth-1:0]    aluCtl,
    output rvIsaPkg::branchE                    branch,
    output logic                                memRd,
    output logic                                memWr,
    output logic                                memToReg,
    output logic                                regWr,
    output logic [2:0]                          memOp,
    output logic                                error,
    output logic                                done
);

    logic push;
    logic pop;
    logic empty;
    logic almostFull;
    frontCfgPkg::fetchEntryT pushEntry;
    frontCfgPkg::fetchEntryT popData;

    fetchUnit #(
        .memDepthLog2(memDepthLog2)
    ) fetchUnit_i (
        .clk       (clk),
        .rstN      (rstN),
        .runEn     (runEn),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .almostFull(almostFull),
        .push      (push),
        .pushEntry (pushEntry)
    );

    instrFifo #(
        .payloadT (frontCfgPkg::fetchEntryT),
        .fifoDepth(fifoDepth)
    ) instrFifo_i (
        .clk       (clk),
        .rstN      (rstN),
        .push      (push),
        .pushData  (pushEntry),
        .pop       (pop),
        .popData   (popData),
        .empty     (empty),
        .almostFull(almostFull)
    );

    instrDecode instrDecode_i (
        .clk     (clk),
        .rstN    (rstN),
        .hold    (hold),
        .empty   (empty),
        .popData (popData),
        .pop     (pop),
        .outValid(outValid),
        .pc      (pc),
        .imm     (imm),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .aluASrc (aluASrc),
        .aluBSrc (aluBSrc),
        .aluCtl  (aluCtl),
        .branch  (branch),
        .memRd   (memRd),
        .memWr   (memWr),
        .memToReg(memToReg),
        .regWr   (regWr),
        .memOp   (memOp),
        .error   (error),
        .done    (done)
    );

endmodule

//--- fetchUnit.sv
module fetchUnit #(
    parameter int memDepthLog2 = 6
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                runEn,
    input  logic                                loadEn,
    input  logic [memDepthLog2-1:0]             loadAddr,
    input  logic [frontCfgPkg::instrWidth-1:0]  loadData,
    input  logic                                almostFull,
    output logic                                push,
    output frontCfgPkg::fetchEntryT             pushEntry
);

    localparam int xl = frontCfgPkg::xlen;

    logic [xl-1:0] pc;
    logic [xl-1:0] flightPc;
    logic [memDepthLog2:0] progLen; // highest loaded index plus one
    logic [frontCfgPkg::instrWidth-1:0] rdData;
    logic inFlight;
    logic inRange;
    logic issue;

    assign inRange = pc[xl-1:2] < {{(xl - 3 - memDepthLog2){1'b0}}, progLen};
    assign issue = runEn && inRange && !almostFull;

    instrMem #(
        .memDepthLog2(memDepthLog2)
    ) instrMem_i (
        .clk     (clk),
        .loadEn  (loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .rdEn    (issue),
        .rdAddr  (pc[memDepthLog2+1:2]),
        .rdData  (rdData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            progLen <= '0;
            inFlight <= 1'b0;
        end else begin
            inFlight <= issue;
            if (issue) begin
                pc <= pc + 'd4;
            end
            if (loadEn && {1'b0, loadAddr} >= progLen) begin
                progLen <= {1'b0, loadAddr} + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            flightPc <= pc;
        end
    end

    assign push = inFlight;
    assign pushEntry = '{pc: flightPc, instr: rdData};

    // a push needs room reserved by the FIFO level one cycle earlier
    assert property (@(posedge clk) disable iff (!rstN) push |-> $past(!almostFull));

endmodule

//--- flist.f
rvIsaPkg.sv
frontCfgPkg.sv
instrMem.sv
fetchUnit.sv
instrFifo.sv
immGen.sv
instrDecode.sv
decodeFrontEnd.sv
tbDecodeFrontEnd.sv

//--- frontCfgPkg.sv
package frontCfgPkg;

    localparam int xlen = 64;
    localparam int instrWidth = 32;

    // one fetched word and where it came from
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [instrWidth-1:0] instr;
    } fetchEntryT;

endpackage

//--- immGen.sv
module immGen (
    input  logic [31:7]                   instrHi,
    input  rvIsaPkg::immFmtE              fmt,
    output logic [frontCfgPkg::xlen-1:0]  imm
);

    localparam int xl = frontCfgPkg::xlen;

    logic sgn;

    assign sgn = instrHi[31];

    always_comb begin
        case (fmt)
            rvIsaPkg::immU: begin
                imm = {{(xl - 32){sgn}}, instrHi[31:12], 12'b0};
            end
            rvIsaPkg::immJ: begin
                imm = {{(xl - 20){sgn}}, instrHi[19:12], instrHi[20], instrHi[30:21], 1'b0};
            end
            rvIsaPkg::immB: begin
                imm = {{(xl - 12){sgn}}, instrHi[7], instrHi[30:25], instrHi[11:8], 1'b0};
            end
            rvIsaPkg::immS: begin
                imm = {{(xl - 11){sgn}}, instrHi[30:25], instrHi[11:7]};
            end
            default: begin
                imm = {{(xl - 11){sgn}}, instrHi[30:20]}; // I format
            end
        endcase
    end

endmodule

//--- instrDecode.sv
module instrDecode (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                hold,
    input  logic                                empty,
    input  frontCfgPkg::fetchEntryT             popData,
    output logic                                pop,
    output logic                                outValid,
    output logic [frontCfgPkg::xlen-1:0]        pc,
    output logic [frontCfgPkg::xlen-1:0]        imm,
    output logic [4:0]                          rs1,
    output logic [4:0]                          rs2,
    output logic [4:0]                          rd,
    output logic                                aluASrc,
    output logic [rvIsaPkg::aluBSrcWidth-1:0]   aluBSrc,
    output logic [rvIsaPkg::aluCtlWidth-1:0]    aluCtl,
    output rvIsaPkg::branchE                    branch,
    output logic                                memRd,
    output logic                                memWr,
    output logic                                memToReg,
    output logic                                regWr,
    output logic [2:0]                          memOp,
    output logic                                error,
    output logic                                done
);

    logic [frontCfgPkg::instrWidth-1:0] instr;
    rvIsaPkg::opClassE cls;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic shiftOp;
    rvIsaPkg::immFmtE dFmt;
    logic [rvIsaPkg::aluBSrcWidth-1:0] dBSrc;
    logic [3:0] dAluLo;
    rvIsaPkg::branchE dBranch;
    logic clsErr;
    logic [frontCfgPkg::xlen-1:0] dImm;

    function automatic logic stdFn7(input logic [6:0] f);
        return (f == 7'b0000000) || (f == 7'b0100000);
    endfunction

    assign instr = popData.instr;
    assign cls = rvIsaPkg::opClassE'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign shiftOp = (funct3[1:0] == 2'b01); // sll or srl/sra

    always_comb begin
        dFmt = rvIsaPkg::immI;
        dBSrc = 2'd0;
        dAluLo = 4'b0000;
        dBranch = rvIsaPkg::brNone;
        clsErr = 1'b0;
        case (cls)
            rvIsaPkg::opSystem: begin
                dBSrc = 2'd1;
                dBranch = rvIsaPkg::brJal; // ebreak
            end
            rvIsaPkg::opLui: begin
                dFmt = rvIsaPkg::immU;
                dBSrc = 2'd2;
                dAluLo = 4'b1111;
            end
            rvIsaPkg::opAuipc: begin
                dFmt = rvIsaPkg::immU;
                dBSrc = 2'd2;
            end
            rvIsaPkg::opJal: begin
                dFmt = rvIsaPkg::immJ;
                dBSrc = 2'd1;
                dBranch = rvIsaPkg::brJal;
            end
            rvIsaPkg::opJalr: begin
                dBSrc = 2'd1;
                dBranch = rvIsaPkg::brJalr;
                clsErr = (funct3 != 3'b000);
            end
            rvIsaPkg::opBranch: begin
                dFmt = rvIsaPkg::immB;
                if (funct3[2:1] == 2'b01) begin
                    clsErr = 1'b1;
                end else begin
                    dAluLo = {3'b001, funct3[1]}; // unsigned compare
                    dBranch = rvIsaPkg::branchE'({1'b1, funct3[2], funct3[0]});
                end
            end
            rvIsaPkg::opLoad: begin
                dBSrc = 2'd2;
                clsErr = (funct3 == 3'b111);
            end
            rvIsaPkg::opStore: begin
                dFmt = rvIsaPkg::immS;
                dBSrc = 2'd2;
                clsErr = funct3[2];
            end
            rvIsaPkg::opOpImm: begin
                dBSrc = 2'd2;
                dAluLo = {funct7[5] && funct3 == 3'b101, funct3};
                clsErr = shiftOp && !stdFn7({funct7[6:1], 1'b0}); // shamt[5] in funct7[0]
            end
            rvIsaPkg::opOpImm32: begin
                dBSrc = 2'd2;
                dAluLo = {funct7[5] && funct3 == 3'b101, funct3};
                clsErr = shiftOp && !stdFn7(funct7);
            end
            rvIsaPkg::opOp: begin
                dAluLo = {funct7[5], funct3};
                clsErr = !(stdFn7(funct7) || funct7 == 7'b0000001); // M extension
            end
            rvIsaPkg::opOp32: begin
                dAluLo = {funct7[5], funct3};
                clsErr = !stdFn7(funct7);
            end
            default: begin
                clsErr = 1'b1;
            end
        endcase
    end

    immGen immGen_i (
        .instrHi(instr[31:7]),
        .fmt    (dFmt),
        .imm    (dImm)
    );

    assign pop = !empty && !hold;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pc <= popData.pc;
            imm <= dImm;
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            rd <= instr[11:7];
            aluASrc <= (cls == rvIsaPkg::opAuipc) || (cls == rvIsaPkg::opJal)
                || (cls == rvIsaPkg::opJalr);
            aluBSrc <= dBSrc;
            aluCtl <= {(cls == rvIsaPkg::opOp32) || (cls == rvIsaPkg::opOp && funct7[0]),
                instr[3] & ~instr[2], dAluLo}; // word ops
            branch <= dBranch;
            memRd <= (cls == rvIsaPkg::opLoad);
            memWr <= (cls == rvIsaPkg::opStore);
            memToReg <= (cls == rvIsaPkg::opLoad);
            regWr <= !((cls == rvIsaPkg::opStore) || (cls == rvIsaPkg::opBranch));
            memOp <= funct3;
            error <= clsErr || (instr[1:0] != 2'b11);
            done <= (cls == rvIsaPkg::opSystem);
        end
    end

    // each pop shows up once, with the popped pc, one cycle later
    assert property (@(posedge clk) disable iff (!rstN)
        pop |=> outValid && (pc == $past(popData.pc)));

endmodule

//--- instrFifo.sv
module instrFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  fifoDepth = 4
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    empty,
    output logic    almostFull
);

    localparam int ptrW = $clog2(fifoDepth);
    localparam int cntW = $clog2(fifoDepth + 1);

    payloadT buffer [fifoDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic full;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
        return (p == ptrW'(fifoDepth - 1)) ? '0 : p + 1'b1; // wraps for any depth
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wrPtr] <= pushData;
        end
    end

    assign popData = buffer[rdPtr]; // head shows without a pop
    assign empty = (count == '0);
    assign full = (count == cntW'(fifoDepth));
    assign almostFull = (count >= cntW'(fifoDepth - 1)); // one slot kept for the read in flight

    assert property (@(posedge clk) disable iff (!rstN) full |-> !push);
    assert property (@(posedge clk) disable iff (!rstN) empty |-> !pop);

endmodule

//--- instrMem.sv
module instrMem #(
    parameter int memDepthLog2 = 6
) (
    input  logic                                clk,
    input  logic                                loadEn,
    input  logic [memDepthLog2-1:0]             loadAddr,
    input  logic [frontCfgPkg::instrWidth-1:0]  loadData,
    input  logic                                rdEn,
    input  logic [memDepthLog2-1:0]             rdAddr,
    output logic [frontCfgPkg::instrWidth-1:0]  rdData
);

    logic [frontCfgPkg::instrWidth-1:0] mem [2**memDepthLog2];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
        if (rdEn) begin
            rdData <= mem[rdAddr]; // one cycle read latency
        end
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbDecodeFrontEnd -f flist.f -o simTb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/simTb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- rvIsaPkg.sv
package rvIsaPkg;

    localparam int aluCtlWidth = 6;
    localparam int aluBSrcWidth = 2;

    // instr[6:2] of the RV64 subset
    typedef enum logic [4:0] {
        opLoad    = 5'b00000,
        opOpImm   = 5'b00100,
        opAuipc   = 5'b00101,
        opOpImm32 = 5'b00110,
        opStore   = 5'b01000,
        opOp      = 5'b01100,
        opLui     = 5'b01101,
        opOp32    = 5'b01110,
        opBranch  = 5'b11000,
        opJalr    = 5'b11001,
        opJal     = 5'b11011,
        opSystem  = 5'b11100
    } opClassE;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } immFmtE;

    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001, // also ebreak
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110, // bltu too
        brGe   = 3'b111  // bgeu too
    } branchE;

endpackage

//--- tbDecodeFrontEnd.sv
module tbDecodeFrontEnd;

    localparam int memDepthLog2 = 6;
    localparam int fifoDepth = 4;

    logic clk;
    logic rstN;
    logic loadEn;
    logic [memDepthLog2-1:0] loadAddr;
    logic [31:0] loadData;
    logic runEn;
    logic hold;
    logic outValid;
    logic [63:0] pc;
    logic [63:0] imm;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic aluASrc;
    logic [rvIsaPkg::aluBSrcWidth-1:0] aluBSrc;
    logic [rvIsaPkg::aluCtlWidth-1:0] aluCtl;
    rvIsaPkg::branchE branch;
    logic memRd;
    logic memWr;
    logic memToReg;
    logic regWr;
    logic [2:0] memOp;
    logic error;
    logic done;

    logic [31:0] prog [64]; // shadow of the loaded program
    int progWords = 0;
    int expIdx;
    logic [7:0] runCycles;
    logic seenOut;
    logic doneSeen;
    logic [31:0] curWord;
    logic [4:0] curOp;
    logic [63:0] expPc;
    logic [63:0] expImm;
    logic [10:0] expCtl;
    logic [4:0] expFlags;
    logic expError;
    logic isLoad;
    logic isStore;
    logic pcRel;
    logic fullCheck;

    decodeFrontEnd #(
        .memDepthLog2(memDepthLog2),
        .fifoDepth   (fifoDepth)
    ) decodeFrontEnd_i (
        .clk     (clk),
        .rstN    (rstN),
        .loadEn  (loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .runEn   (runEn),
        .hold    (hold),
        .outValid(outValid),
        .pc      (pc),
        .imm     (imm),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .aluASrc (aluASrc),
        .aluBSrc (aluBSrc),
        .aluCtl  (aluCtl),
        .branch  (branch),
        .memRd   (memRd),
        .memWr   (memWr),
        .memToReg(memToReg),
        .regWr   (regWr),
        .memOp   (memOp),
        .error   (error),
        .done    (done)
    );

    task automatic failWith(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        failWith($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] mkWord(input logic [6:0] f7, input logic [4:0] f2,
        input logic [4:0] f1, input logic [2:0] f3, input logic [4:0] fd, input logic [4:0] op5);
        return {f7, f2, f1, f3, fd, op5, 2'b11};
    endfunction

    function automatic logic isIllegal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic shift;
        logic bad;
        f3 = w[14:12];
        f7 = w[31:25];
        shift = (f3 == 3'd1) || (f3 == 3'd5);
        bad = (w[1:0] != 2'b11);
        case (w[6:2])
            rvIsaPkg::opJalr: bad = bad || (f3 != 3'd0);
            rvIsaPkg::opBranch: bad = bad || (f3 == 3'd2) || (f3 == 3'd3);
            rvIsaPkg::opLoad: bad = bad || (f3 == 3'd7);
            rvIsaPkg::opStore: bad = bad || (f3 > 3'd3);
            rvIsaPkg::opOpImm: begin
                // shamt bit 5 sits in funct7[0]
                bad = bad || (shift && f7[6:1] != 6'b000000 && f7[6:1] != 6'b010000);
            end
            rvIsaPkg::opOpImm32: bad = bad || (shift && f7 != 7'h00 && f7 != 7'h20);
            rvIsaPkg::opOp: bad = bad || (f7 != 7'h00 && f7 != 7'h20 && f7 != 7'h01);
            rvIsaPkg::opOp32: bad = bad || (f7 != 7'h00 && f7 != 7'h20);
            rvIsaPkg::opLui, rvIsaPkg::opAuipc, rvIsaPkg::opJal, rvIsaPkg::opSystem: ;
            default: bad = 1'b1;
        endcase
        return bad;
    endfunction

    function automatic logic [63:0] immFor(input logic [31:0] w);
        logic signed [63:0] v;
        case (w[6:2])
            rvIsaPkg::opLui, rvIsaPkg::opAuipc: v = $signed({w[31:12], 12'h000});
            rvIsaPkg::opJal: v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            rvIsaPkg::opBranch: v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            rvIsaPkg::opStore: v = $signed({w[31:25], w[11:7]});
            default: v = $signed(w[31:20]);
        endcase
        return v;
    endfunction

    // {aluBSrc, aluCtl, branch} for a legal word
    function automatic logic [10:0] ctlFor(input logic [31:0] w);
        logic [1:0] bSel;
        logic [3:0] lo;
        logic [2:0] br;
        logic [2:0] f3;
        logic word32;
        logic mulDiv;
        f3 = w[14:12];
        bSel = 2'd2;
        lo = 4'h0;
        br = rvIsaPkg::brNone;
        word32 = (w[6:2] == rvIsaPkg::opOpImm32) || (w[6:2] == rvIsaPkg::opOp32);
        mulDiv = (w[6:2] == rvIsaPkg::opOp32) || (w[6:2] == rvIsaPkg::opOp && w[25]);
        case (w[6:2])
            rvIsaPkg::opLui: lo = 4'hf;
            rvIsaPkg::opJal, rvIsaPkg::opSystem: begin
                bSel = 2'd1;
                br = rvIsaPkg::brJal;
            end
            rvIsaPkg::opJalr: begin
                bSel = 2'd1;
                br = rvIsaPkg::brJalr;
            end
            rvIsaPkg::opBranch: begin
                bSel = 2'd0;
                lo = f3[1] ? 4'h3 : 4'h2; // unsigned compares
                if (f3[2]) begin
                    br = f3[0] ? rvIsaPkg::brGe : rvIsaPkg::brLt;
                end else begin
                    br = f3[0] ? rvIsaPkg::brNe : rvIsaPkg::brEq;
                end
            end
            rvIsaPkg::opOpImm, rvIsaPkg::opOpImm32: lo = {f3 == 3'd5 && w[30], f3};
            rvIsaPkg::opOp, rvIsaPkg::opOp32: begin
                bSel = 2'd0;
                lo = {w[30], f3};
            end
            default: ;
        endcase
        return {bSel, mulDiv, word32, lo, br};
    endfunction

    task automatic addWord(input logic [31:0] w);
        prog[progWords] = w;
        progWords++;
    endtask

    task automatic buildProgram();
        addWord(mkWord(7'h7f, 5'd31, 5'd3, 3'd5, 5'd1, rvIsaPkg::opLui));
        addWord(mkWord(7'h01, 5'd2, 5'd0, 3'd0, 5'd2, rvIsaPkg::opAuipc));
        addWord(mkWord(7'h40, 5'd3, 5'd9, 3'd2, 5'd1, rvIsaPkg::opJal));
        addWord(mkWord(7'h12, 5'd7, 5'd4, 3'd6, 5'd5, rvIsaPkg::opJal));
        addWord(mkWord(7'h7f, 5'd28, 5'd1, 3'd0, 5'd0, rvIsaPkg::opJalr));
        addWord(mkWord(7'h00, 5'd8, 5'd1, 3'd1, 5'd1, rvIsaPkg::opJalr)); // bad funct3
        addWord(mkWord(7'h02, 5'd2, 5'd1, 3'd0, 5'd8, rvIsaPkg::opBranch));
        addWord(mkWord(7'h7e, 5'd5, 5'd6, 3'd1, 5'd9, rvIsaPkg::opBranch));
        addWord(mkWord(7'h10, 5'd3, 5'd4, 3'd4, 5'd16, rvIsaPkg::opBranch));
        addWord(mkWord(7'h41, 5'd7, 5'd2, 3'd7, 5'd31, rvIsaPkg::opBranch));
        addWord(mkWord(7'h00, 5'd1, 5'd2, 3'd2, 5'd4, rvIsaPkg::opBranch));
        addWord(mkWord(7'h00, 5'd1, 5'd2, 3'd3, 5'd4, rvIsaPkg::opBranch));
        addWord(mkWord(7'h7f, 5'd24, 5'd2, 3'd3, 5'd10, rvIsaPkg::opLoad));
        addWord(mkWord(7'h00, 5'd12, 5'd2, 3'd4, 5'd11, rvIsaPkg::opLoad));
        addWord(mkWord(7'h00, 5'd12, 5'd2, 3'd7, 5'd11, rvIsaPkg::opLoad));
        addWord(mkWord(7'h7f, 5'd11, 5'd2, 3'd3, 5'd24, rvIsaPkg::opStore));
        addWord(mkWord(7'h01, 5'd12, 5'd3, 3'd0, 5'd4, rvIsaPkg::opStore));
        addWord(mkWord(7'h01, 5'd12, 5'd3, 3'd4, 5'd4, rvIsaPkg::opStore));
        addWord(mkWord(7'h70, 5'd1, 5'd5, 3'd0, 5'd6, rvIsaPkg::opOpImm));
        addWord(mkWord(7'h21, 5'd3, 5'd5, 3'd5, 5'd6, rvIsaPkg::opOpImm)); // srai by 35
        addWord(mkWord(7'h04, 5'd1, 5'd5, 3'd1, 5'd6, rvIsaPkg::opOpImm));
        addWord(mkWord(7'h55, 5'd9, 5'd7, 3'd0, 5'd8, rvIsaPkg::opOpImm32));
        addWord(mkWord(7'h20, 5'd4, 5'd7, 3'd5, 5'd8, rvIsaPkg::opOpImm32));
        addWord(mkWord(7'h01, 5'd4, 5'd7, 3'd1, 5'd8, rvIsaPkg::opOpImm32));
        addWord(mkWord(7'h00, 5'd2, 5'd3, 3'd0, 5'd4, rvIsaPkg::opOp));
        addWord(mkWord(7'h20, 5'd2, 5'd3, 3'd0, 5'd4, rvIsaPkg::opOp));
        addWord(mkWord(7'h01, 5'd2, 5'd3, 3'd0, 5'd4, rvIsaPkg::opOp)); // mul
        addWord(mkWord(7'h10, 5'd2, 5'd3, 3'd0, 5'd4, rvIsaPkg::opOp));
        addWord(mkWord(7'h00, 5'd6, 5'd7, 3'd0, 5'd8, rvIsaPkg::opOp32));
        addWord(mkWord(7'h20, 5'd6, 5'd7, 3'd5, 5'd8, rvIsaPkg::opOp32));
        addWord(mkWord(7'h01, 5'd6, 5'd7, 3'd0, 5'd8, rvIsaPkg::opOp32));
        addWord(mkWord(7'h70, 5'd1, 5'd5, 3'd0, 5'd6, rvIsaPkg::opOpImm) ^ 32'h1);
        addWord(mkWord(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 5'b00011)); // fence, not decoded
        addWord(mkWord(7'h00, 5'd1, 5'd0, 3'd0, 5'd0, rvIsaPkg::opSystem)); // ebreak
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progWords; i++) begin
            @(negedge clk);
            loadEn = 1'b1;
            loadAddr = memDepthLog2'(i);
            loadData = prog[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    assign curWord = prog[expIdx];
    assign curOp = curWord[6:2];
    assign expPc = 64'(expIdx) << 2;
    assign expImm = immFor(curWord);
    assign expCtl = ctlFor(curWord);
    assign expError = isIllegal(curWord);
    assign isLoad = (curOp == rvIsaPkg::opLoad);
    assign isStore = (curOp == rvIsaPkg::opStore);
    assign pcRel = (curOp == rvIsaPkg::opAuipc) || (curOp == rvIsaPkg::opJal)
        || (curOp == rvIsaPkg::opJalr);
    assign expFlags = {pcRel, isLoad, isStore, isLoad, !(isStore || curOp == rvIsaPkg::opBranch)};
    assign fullCheck = outValid && !expError; // control fields of legal words

    always_ff @(posedge clk) begin
        if (!rstN) begin
            expIdx <= 0;
            runCycles <= '0;
            seenOut <= 1'b0;
            doneSeen <= 1'b0;
        end else begin
            if (outValid) begin
                expIdx <= expIdx + 1;
                seenOut <= 1'b1;
                doneSeen <= doneSeen || done;
            end
            if (runEn && runCycles != 8'hff) begin
                runCycles <= runCycles + 8'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !runEn |-> !outValid)
        else failWith("outValid was raised before runEn");
    assert property (@(posedge clk) disable iff (!rstN)
        runEn && !seenOut |-> outValid == (runCycles == 8'd3))
        else failWith("first outValid did not come 3 cycles after runEn");
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> expIdx < progWords)
        else failWith("outValid seen past the end of the program");
    assert property (@(posedge clk) disable iff (!rstN) doneSeen |-> !outValid)
        else failWith("outValid seen after the ebreak");
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> pc == expPc)
        else mismatch("pc", $sampled(pc), $sampled(expPc));
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> error == expError)
        else mismatch("error", $sampled(error), $sampled(expError));
    assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> done == (curOp == rvIsaPkg::opSystem))
        else mismatch("done", $sampled(done), $sampled(curOp == rvIsaPkg::opSystem));
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> imm == expImm)
        else mismatch("imm", $sampled(imm), $sampled(expImm));
    assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> {rs1, rs2, rd, memOp} == {curWord[19:15], curWord[24:20],
        curWord[11:7], curWord[14:12]})
        else mismatch("{rs1,rs2,rd,memOp}", $sampled({rs1, rs2, rd, memOp}),
            $sampled({curWord[19:15], curWord[24:20], curWord[11:7], curWord[14:12]}));
    assert property (@(posedge clk) disable iff (!rstN)
        fullCheck |-> {aluASrc, memRd, memWr, memToReg, regWr} == expFlags)
        else mismatch("{aluASrc,memRd,memWr,memToReg,regWr}",
            $sampled({aluASrc, memRd, memWr, memToReg, regWr}), $sampled(expFlags));
    assert property (@(posedge clk) disable iff (!rstN)
        fullCheck |-> {aluBSrc, aluCtl, branch} == expCtl)
        else mismatch("{aluBSrc,aluCtl,branch}", $sampled({aluBSrc, aluCtl, branch}),
            $sampled(expCtl));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int waitCnt;
        logic [31:0] lfsr;
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        runEn = 1'b0;
        hold = 1'b0;
        lfsr = 32'h50d8_d1ac;
        buildProgram();
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        loadProgram();
        repeat (4) @(negedge clk); // loaded but not running yet
        runEn = 1'b1;
        waitCnt = 0;
        while (!outValid) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 20) begin
                failWith("timeout waiting for the first decoded instruction");
            end
        end
        waitCnt = 0;
        while (!doneSeen) begin
            lfsr = lfsrStep(lfsr);
            hold = lfsr[0];
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 2000) begin
                failWith("timeout waiting for the ebreak to be decoded");
            end
        end
        hold = 1'b0;
        repeat (20) @(negedge clk); // quiet tail after done
        if (expIdx != progWords) begin
            failWith($sformatf("only %0d of %0d instructions were decoded", expIdx, progWords));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
